/* sim.f */
+incdir+source
+incdir+sim
source/desc_pkg.sv
source/msg_pkg.sv
source/desc_fifo.sv
source/sched_ctrl_in.sv
source/send_desc_path.sv
source/ctrl_out_path.sv
source/core_msg_bridge.sv
source/riscv_ctrl_wrapper.sv
sim/tb_riscv_ctrl_wrapper.sv

/* sim/tb_ctrl_vectors.svh */
////////////////////////////////////////////////////////////////////////////
// Stimulus table, included inside the testbench module. Only bit 0 of a
// table payload is used, the rest of each payload comes from $urandom
////////////////////////////////////////////////////////////////////////////
`ifndef TB_CTRL_VECTORS_SVH
`define TB_CTRL_VECTORS_SVH

typedef enum logic [3:0] {
  K_IDLE,
  K_RESET_CMD,
  K_SCHED,
  K_CORE_DATA,
  // Scheduler and core data descriptor in the same cycle
  K_BOTH,
  K_CORE_CTRL,
  K_PKT_SENT,
  K_MSG_OUT,
  K_MSG_IN
} vec_kind_t;

typedef struct packed {
  vec_kind_t   kind;
  // Bit 0 is the reset command value or the DMEM half of a message
  logic [63:0] payload;
  // Sink readys: send_desc, ctrl_m, core_msg_out
  logic [2:0]  rdy;
  // Idle length, stretched at random by up to 3 cycles
  logic [3:0]  cycles;
  // core_reset expected after a reset command
  logic        exp_reset;
} vec_t;

localparam int NUM_VEC = 46;

localparam vec_t VEC_TABLE [NUM_VEC] = '{
  // Reset state, core release, first sends
  '{K_IDLE,      64'd0, 3'b111, 4'd2,  1'b1},
  '{K_RESET_CMD, 64'd0, 3'b111, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b111, 4'd0,  1'b0},
  '{K_CORE_DATA, 64'd0, 3'b111, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b111, 4'd2,  1'b0},
  '{K_PKT_SENT,  64'd0, 3'b111, 4'd0,  1'b0},
  // Both heads waiting behind a stalled DMA
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_CORE_DATA, 64'd0, 3'b000, 4'd0,  1'b0},
  '{K_BOTH,      64'd0, 3'b000, 4'd0,  1'b0},
  '{K_CORE_DATA, 64'd0, 3'b000, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b000, 4'd3,  1'b0},
  '{K_IDLE,      64'd0, 3'b111, 4'd6,  1'b0},
  // Releases against core control under ctrl_m back-pressure
  '{K_PKT_SENT,  64'd0, 3'b101, 4'd0,  1'b0},
  '{K_CORE_CTRL, 64'd0, 3'b101, 4'd0,  1'b0},
  '{K_PKT_SENT,  64'd0, 3'b101, 4'd0,  1'b0},
  '{K_CORE_CTRL, 64'd0, 3'b101, 4'd0,  1'b0},
  '{K_CORE_CTRL, 64'd0, 3'b101, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b101, 4'd2,  1'b0},
  '{K_IDLE,      64'd0, 3'b111, 4'd5,  1'b0},
  // Fill the scheduler queue, ctrl_s_tready must drop
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_SCHED,     64'd0, 3'b000, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b000, 4'd2,  1'b0},
  '{K_IDLE,      64'd0, 3'b111, 4'd10, 1'b0},
  // Reset commands, never forwarded
  '{K_RESET_CMD, 64'd1, 3'b111, 4'd0,  1'b1},
  '{K_RESET_CMD, 64'd0, 3'b111, 4'd0,  1'b0},
  // Broadcast messages, both DMEM halves
  '{K_MSG_OUT,   64'd0, 3'b110, 4'd0,  1'b0},
  '{K_MSG_OUT,   64'd0, 3'b110, 4'd0,  1'b0},
  '{K_MSG_IN,    64'd0, 3'b110, 4'd0,  1'b0},
  '{K_MSG_IN,    64'd1, 3'b110, 4'd0,  1'b0},
  '{K_MSG_OUT,   64'd0, 3'b111, 4'd0,  1'b0},
  '{K_MSG_IN,    64'd1, 3'b111, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b111, 4'd3,  1'b0},
  // Mixed stalls, then drain everything
  '{K_SCHED,     64'd0, 3'b010, 4'd0,  1'b0},
  '{K_CORE_CTRL, 64'd0, 3'b010, 4'd0,  1'b0},
  '{K_PKT_SENT,  64'd0, 3'b100, 4'd0,  1'b0},
  '{K_MSG_OUT,   64'd0, 3'b100, 4'd0,  1'b0},
  '{K_BOTH,      64'd0, 3'b001, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b001, 4'd4,  1'b0},
  '{K_PKT_SENT,  64'd0, 3'b111, 4'd0,  1'b0},
  '{K_IDLE,      64'd0, 3'b111, 4'd12, 1'b0}
};

`endif

/* sim/tb_riscv_ctrl_wrapper.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench of the control plane. Inputs change 10 ns after the rising
// edge, outputs and the reference model are sampled on the falling edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_ctrl_defs.svh"

module tb_riscv_ctrl_wrapper import desc_pkg::*, msg_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 10;
  localparam int RESET_CYCLES = 8;
  localparam int SEED         = 32'h39a7_6c3d;
  // Cycle budget per table entry
  localparam int VEC_CYCLES   = 40;

  `include "tb_ctrl_vectors.svh"

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals
  logic                        clk;
  logic                        rst;
  desc_t                       ctrl_s_tdata;
  logic                        ctrl_s_tvalid;
  logic                        ctrl_s_tready;
  desc_t                       ctrl_m_tdata;
  logic                        ctrl_m_tvalid;
  logic                        ctrl_m_tready;
  logic [`CORE_ID_WIDTH-1:0]   ctrl_m_tuser;
  logic                        core_reset;
  desc_t                       core_data_desc;
  logic                        core_data_desc_valid;
  logic                        core_data_desc_ready;
  desc_t                       core_ctrl_desc;
  logic                        core_ctrl_desc_valid;
  logic                        core_ctrl_desc_ready;
  desc_t                       send_desc;
  logic                        send_desc_valid;
  logic                        send_desc_ready;
  logic                        pkt_sent;
  msg_t                        core_msg;
  logic                        core_msg_valid;
  logic                        core_msg_ready;
  msg_t                        core_msg_out_data;
  logic                        core_msg_out_valid;
  logic                        core_msg_out_ready;
  msg_t                        core_msg_in_data;
  logic                        core_msg_in_valid;
  logic                        dmem_wr_en;
  logic [`DMEM_ADDR_WIDTH-1:0] dmem_wr_addr;
  logic [7:0]                  dmem_wr_strb;
  logic [63:0]                 dmem_wr_data;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state
  desc_t     sched_q[$];
  desc_t     data_q[$];
  desc_t     rel_q[$];
  desc_t     ctl_q[$];
  msg_t      msg_q[$];
  // A stalled offer keeps its source until it transfers
  logic      send_lock;
  send_src_t send_held;
  logic      ctrl_lock;
  ctrl_src_t ctrl_held;
  desc_t     last_sent;
  logic      sent_any;
  logic      exp_core_reset;
  logic      exp_wr_en;
  msg_t      wr_msg;
  logic      mon_on;

  riscv_ctrl_wrapper dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, one model step per cycle
  task automatic check_readys();
    check("ctrl_s_tready", ctrl_s_tready, sched_q.size() < `DESC_FIFO_DEPTH);
    check("core_data_desc_ready", core_data_desc_ready, data_q.size() < `DESC_FIFO_DEPTH);
    check("core_ctrl_desc_ready", core_ctrl_desc_ready, ctl_q.size() < `DESC_FIFO_DEPTH);
    check("core_msg_ready", core_msg_ready, msg_q.size() < `MSG_FIFO_DEPTH);
    check("core_reset", core_reset, exp_core_reset);
  endtask

  task automatic check_ctrl_out();
    ctrl_src_t src;
    // Release first unless a core control offer is already stalled
    src = SRC_CORE_CTRL;
    if (ctrl_lock)
      src = ctrl_held;
    else if (rel_q.size() != 0)
      src = SRC_RELEASE;
    check("ctrl_m_tuser", ctrl_m_tuser, `CORE_ID);
    check("ctrl_m_tvalid", ctrl_m_tvalid, rel_q.size() != 0 || ctl_q.size() != 0);
    if (ctrl_m_tvalid) begin
      check("ctrl_m_tdata", ctrl_m_tdata, (src == SRC_RELEASE) ? rel_q[0] : ctl_q[0]);
      if (ctrl_m_tready && src == SRC_RELEASE)
        void'(rel_q.pop_front());
      else if (ctrl_m_tready)
        void'(ctl_q.pop_front());
    end
    ctrl_lock = ctrl_m_tvalid && !ctrl_m_tready;
    ctrl_held = src;
  endtask

  task automatic check_send();
    send_src_t src;
    // Scheduler first unless a core data offer is already stalled
    src = SRC_CORE_DATA;
    if (send_lock)
      src = send_held;
    else if (sched_q.size() != 0)
      src = SRC_SCHED;
    check("send_desc_valid", send_desc_valid, sched_q.size() != 0 || data_q.size() != 0);
    if (send_desc_valid) begin
      check("send_desc", send_desc, (src == SRC_SCHED) ? sched_q[0] : data_q[0]);
      if (send_desc_ready) begin
        if (src == SRC_SCHED)
          void'(sched_q.pop_front());
        else
          void'(data_q.pop_front());
        last_sent = send_desc;
        sent_any  = 1'b1;
      end
    end
    send_lock = send_desc_valid && !send_desc_ready;
    send_held = src;
  endtask

  task automatic check_msgs();
    logic [3:0]                  strb;
    logic [`DMEM_ADDR_WIDTH-1:0] addr;
    logic [31:0]                 data;
    check("core_msg_out_valid", core_msg_out_valid, msg_q.size() != 0);
    if (core_msg_out_valid) begin
      check("core_msg_out_data", core_msg_out_data, msg_q[0]);
      if (core_msg_out_ready)
        void'(msg_q.pop_front());
    end
    // One write, the cycle after the strobe
    check("dmem_wr_en", dmem_wr_en, exp_wr_en);
    if (exp_wr_en) begin
      strb = wr_msg[`MSG_WIDTH-1 -: 4];
      addr = wr_msg[32 +: `DMEM_ADDR_WIDTH];
      data = wr_msg[31:0];
      check("dmem_wr_addr", dmem_wr_addr, addr);
      // Address bit 2 moves strobe and data into the upper half
      check("dmem_wr_strb", dmem_wr_strb, 8'(strb) << (addr[2] * 4));
      check("dmem_wr_data", dmem_wr_data, 64'(data) << (addr[2] * 32));
    end
  endtask

  task automatic take_inputs();
    if (ctrl_s_tvalid && ctrl_s_tready) begin
      if (ctrl_s_tdata[`CTRL_DATA_WIDTH-1 -: 8] == `RESET_CMD_BYTE)
        exp_core_reset = ctrl_s_tdata[0];
      else
        sched_q.push_back(ctrl_s_tdata);
    end
    if (core_data_desc_valid && core_data_desc_ready)
      data_q.push_back(core_data_desc);
    if (core_ctrl_desc_valid && core_ctrl_desc_ready)
      ctl_q.push_back(core_ctrl_desc);
    if (core_msg_valid && core_msg_ready)
      msg_q.push_back(core_msg);
    exp_wr_en = core_msg_in_valid;
    wr_msg    = core_msg_in_data;
  endtask

  // Inputs are stable here, so these values are what the next edge takes
  always @(negedge clk) begin
    if (mon_on) begin
      check_readys();
      check_ctrl_out();
      // Release takes the descriptor latched before this edge
      if (pkt_sent)
        rel_q.push_back(last_sent);
      check_send();
      check_msgs();
      take_inputs();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic desc_t random_desc();
    desc_t d;
    d = {$urandom, $urandom};
    // Keep send descriptors clear of the reset marker
    if (d[`CTRL_DATA_WIDTH-1 -: 8] == `RESET_CMD_BYTE)
      d[`CTRL_DATA_WIDTH-1] = 1'b0;
    return d;
  endfunction

  // Holds every raised valid until its transfer
  task automatic run_handshakes();
    logic s_acc;
    logic d_acc;
    logic c_acc;
    logic m_acc;
    while (ctrl_s_tvalid || core_data_desc_valid || core_ctrl_desc_valid || core_msg_valid) begin
      @(negedge clk);
      s_acc = ctrl_s_tvalid && ctrl_s_tready;
      d_acc = core_data_desc_valid && core_data_desc_ready;
      c_acc = core_ctrl_desc_valid && core_ctrl_desc_ready;
      m_acc = core_msg_valid && core_msg_ready;
      next_cycle();
      if (s_acc)
        ctrl_s_tvalid = 1'b0;
      if (d_acc)
        core_data_desc_valid = 1'b0;
      if (c_acc)
        core_ctrl_desc_valid = 1'b0;
      if (m_acc)
        core_msg_valid = 1'b0;
    end
  endtask

  task automatic apply_entry(input vec_t v);
    desc_t       d;
    msg_t        m;
    logic [63:0] r;
    send_desc_ready    = v.rdy[2];
    ctrl_m_tready      = v.rdy[1];
    core_msg_out_ready = v.rdy[0];
    d = random_desc();
    r = {$urandom, $urandom};
    m = r[`MSG_WIDTH-1:0];
    case (v.kind)
      K_RESET_CMD: begin
        d[`CTRL_DATA_WIDTH-1 -: 8] = `RESET_CMD_BYTE;
        d[0]          = v.payload[0];
        ctrl_s_tdata  = d;
        ctrl_s_tvalid = 1'b1;
        run_handshakes();
        check("core_reset", core_reset, v.exp_reset);
      end
      K_SCHED, K_BOTH: begin
        ctrl_s_tdata  = d;
        ctrl_s_tvalid = 1'b1;
        if (v.kind == K_BOTH) begin
          core_data_desc       = random_desc();
          core_data_desc_valid = 1'b1;
        end
        run_handshakes();
      end
      K_CORE_DATA: begin
        core_data_desc       = d;
        core_data_desc_valid = 1'b1;
        run_handshakes();
      end
      K_CORE_CTRL: begin
        core_ctrl_desc       = d;
        core_ctrl_desc_valid = 1'b1;
        run_handshakes();
      end
      K_PKT_SENT: begin
        // Needs a latched descriptor and a free release slot
        while (!sent_any || rel_q.size() >= `DESC_FIFO_DEPTH)
          next_cycle();
        pkt_sent = 1'b1;
        next_cycle();
        pkt_sent = 1'b0;
      end
      K_MSG_OUT: begin
        core_msg       = m;
        core_msg_valid = 1'b1;
        run_handshakes();
      end
      K_MSG_IN: begin
        // Address bit 2 sits at message bit 34
        m[32 + 2]         = v.payload[0];
        core_msg_in_data  = m;
        core_msg_in_valid = 1'b1;
        next_cycle();
        core_msg_in_valid = 1'b0;
      end
      default: begin
        repeat (v.cycles + $urandom_range(3, 0))
          next_cycle();
      end
    endcase
  endtask

  initial begin
    void'($urandom(SEED));
    mon_on         = 1'b0;
    send_lock      = 1'b0;
    send_held      = SRC_SCHED;
    ctrl_lock      = 1'b0;
    ctrl_held      = SRC_RELEASE;
    last_sent      = '0;
    sent_any       = 1'b0;
    exp_core_reset = 1'b1;
    exp_wr_en      = 1'b0;
    wr_msg         = '0;
    rst                  = 1'b1;
    ctrl_s_tdata         = '0;
    ctrl_s_tvalid        = 1'b0;
    ctrl_m_tready        = 1'b1;
    core_data_desc       = '0;
    core_data_desc_valid = 1'b0;
    core_ctrl_desc       = '0;
    core_ctrl_desc_valid = 1'b0;
    send_desc_ready      = 1'b1;
    pkt_sent             = 1'b0;
    core_msg             = '0;
    core_msg_valid       = 1'b0;
    core_msg_out_ready   = 1'b1;
    core_msg_in_data     = '0;
    core_msg_in_valid    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst    = 1'b0;
    mon_on = 1'b1;
    for (int i = 0; i < NUM_VEC; i++)
      apply_entry(VEC_TABLE[i]);
    // Nothing lost, every queued word came out
    check("scheduler words left", sched_q.size(), 0);
    check("core data words left", data_q.size(), 0);
    check("release words left", rel_q.size(), 0);
    check("core control words left", ctl_q.size(), 0);
    check("message words left", msg_q.size(), 0);
    $display("TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_VEC * VEC_CYCLES));
    $display("Timeout: the table did not finish, a handshake never completed");
    $display("TESTS FAILED");
    $fatal(1);
  end

endmodule

/* source/riscv_ctrl_wrapper.sv */
////////////////////////////////////////////////////////////////////////////
// Control plane of the core wrapper. Core, DMA engine and DMEM arbiter
// live outside, their descriptor and message ports come out here
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_ctrl_defs.svh"

module riscv_ctrl_wrapper import desc_pkg::*, msg_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,

  // Scheduler control in
  input  desc_t                       ctrl_s_tdata,
  input  logic                        ctrl_s_tvalid,
  output logic                        ctrl_s_tready,

  // Scheduler control out
  output desc_t                       ctrl_m_tdata,
  output logic                        ctrl_m_tvalid,
  input  logic                        ctrl_m_tready,
  output logic [`CORE_ID_WIDTH-1:0]   ctrl_m_tuser,

  // Core side
  output logic                        core_reset,
  input  desc_t                       core_data_desc,
  input  logic                        core_data_desc_valid,
  output logic                        core_data_desc_ready,
  input  desc_t                       core_ctrl_desc,
  input  logic                        core_ctrl_desc_valid,
  output logic                        core_ctrl_desc_ready,

  // DMA side
  output desc_t                       send_desc,
  output logic                        send_desc_valid,
  input  logic                        send_desc_ready,
  input  logic                        pkt_sent,

  // Broadcast messages
  input  msg_t                        core_msg,
  input  logic                        core_msg_valid,
  output logic                        core_msg_ready,
  output msg_t                        core_msg_out_data,
  output logic                        core_msg_out_valid,
  input  logic                        core_msg_out_ready,
  input  msg_t                        core_msg_in_data,
  input  logic                        core_msg_in_valid,

  // DMEM write port
  output logic                        dmem_wr_en,
  output logic [`DMEM_ADDR_WIDTH-1:0] dmem_wr_addr,
  output logic [7:0]                  dmem_wr_strb,
  output logic [63:0]                 dmem_wr_data
);

  // Scheduler queue head into the send arbiter
  desc_t sched_desc;
  logic  sched_desc_valid;
  logic  sched_desc_ready;
  // Descriptor last granted to the DMA
  desc_t sent_desc_latched;

  assign ctrl_m_tuser = `CORE_ID;

  sched_ctrl_in sched_in (.*);

  send_desc_path send_path (.*);

  ctrl_out_path ctrl_out (.*);

  core_msg_bridge msg_bridge (.*);

endmodule

/* source/core_msg_bridge.sv */
////////////////////////////////////////////////////////////////////////////
// Broadcast messages. Incoming strobe has no back-pressure and always
// wins the DMEM port in the cycle after it arrives
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_ctrl_defs.svh"

module core_msg_bridge import msg_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  msg_t                        core_msg,
  input  logic                        core_msg_valid,
  output logic                        core_msg_ready,
  output msg_t                        core_msg_out_data,
  output logic                        core_msg_out_valid,
  input  logic                        core_msg_out_ready,
  input  msg_t                        core_msg_in_data,
  input  logic                        core_msg_in_valid,
  output logic                        dmem_wr_en,
  output logic [`DMEM_ADDR_WIDTH-1:0] dmem_wr_addr,
  output logic [7:0]                  dmem_wr_strb,
  output logic [63:0]                 dmem_wr_data
);

  msg_strb_t  in_strb;
  msg_addr_t  in_addr;
  msg_data_t  in_data;
  word_half_t half;

  // Outgoing queue toward the broadcast network
  desc_fifo #(
    .DEPTH(`MSG_FIFO_DEPTH),
    .WIDTH(`MSG_WIDTH)
  ) msg_out_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (core_msg_valid),
    .din       (core_msg),
    .din_ready (core_msg_ready),
    .dout_valid(core_msg_out_valid),
    .dout      (core_msg_out_data),
    .dout_ready(core_msg_out_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Incoming message register
  always_ff @(posedge clk) begin
    in_strb <= core_msg_in_data[MSG_STRB_LSB +: 4];
    in_addr <= core_msg_in_data[MSG_ADDR_LSB +: `DMEM_ADDR_WIDTH];
    in_data <= core_msg_in_data[MSG_DATA_LSB +: 32];
  end

  always_ff @(posedge clk) begin
    if (rst)
      dmem_wr_en <= 1'b0;
    else
      dmem_wr_en <= core_msg_in_valid;
  end

  // Bit 2 picks the 32-bit lane of the 64-bit word
  assign half         = word_half_t'(in_addr[2]);
  assign dmem_wr_addr = in_addr;
  assign dmem_wr_strb = (half == HALF_HIGH) ? {in_strb, 4'b0000} : {4'b0000, in_strb};
  assign dmem_wr_data = (half == HALF_HIGH) ? {in_data, 32'd0} : {32'd0, in_data};

endmodule

/* source/ctrl_out_path.sv */
////////////////////////////////////////////////////////////////////////////
// Control output to the scheduler. pkt_sent has no back-pressure, the
// release queue must never be full when it fires
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_ctrl_defs.svh"

module ctrl_out_path import desc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  pkt_sent,
  input  desc_t sent_desc_latched,
  input  desc_t core_ctrl_desc,
  input  logic  core_ctrl_desc_valid,
  output logic  core_ctrl_desc_ready,
  output desc_t ctrl_m_tdata,
  output logic  ctrl_m_tvalid,
  input  logic  ctrl_m_tready
);

  desc_t     rel_head;
  logic      rel_head_valid;
  logic      rel_head_ready;
  logic      rel_in_ready;
  desc_t     ctl_head;
  logic      ctl_head_valid;
  logic      ctl_head_ready;
  ctrl_src_t grant;
  ctrl_src_t held_grant;
  logic      locked;

  // Released descriptors back to the scheduler
  desc_fifo #(
    .DEPTH(`DESC_FIFO_DEPTH),
    .WIDTH($bits(desc_t))
  ) release_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (pkt_sent),
    .din       (sent_desc_latched),
    .din_ready (rel_in_ready),
    .dout_valid(rel_head_valid),
    .dout      (rel_head),
    .dout_ready(rel_head_ready)
  );

  // Core control messages
  desc_fifo #(
    .DEPTH(`DESC_FIFO_DEPTH),
    .WIDTH($bits(desc_t))
  ) core_ctrl_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (core_ctrl_desc_valid),
    .din       (core_ctrl_desc),
    .din_ready (core_ctrl_desc_ready),
    .dout_valid(ctl_head_valid),
    .dout      (ctl_head),
    .dout_ready(ctl_head_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Release first, grant frozen under back-pressure
  always_comb begin
    if (locked)
      grant = held_grant;
    else if (rel_head_valid)
      grant = SRC_RELEASE;
    else
      grant = SRC_CORE_CTRL;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked     <= 1'b0;
      held_grant <= SRC_RELEASE;
    end else begin
      locked     <= ctrl_m_tvalid && !ctrl_m_tready;
      held_grant <= grant;
    end
  end

  assign ctrl_m_tvalid  = rel_head_valid || ctl_head_valid;
  assign ctrl_m_tdata   = (grant == SRC_RELEASE) ? rel_head : ctl_head;
  assign rel_head_ready = ctrl_m_tready && (grant == SRC_RELEASE);
  assign ctl_head_ready = ctrl_m_tready && (grant == SRC_CORE_CTRL);

  // Strobe into a full release queue loses a slot for good
  a_no_lost_release: assert property (@(posedge clk) disable iff (rst)
    pkt_sent |-> rel_in_ready);

endmodule

/* source/send_desc_path.sv */
////////////////////////////////////////////////////////////////////////////
// Send arbiter, scheduler first. A grant stays fixed while the DMA stalls
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_ctrl_defs.svh"

module send_desc_path import desc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  desc_t sched_desc,
  input  logic  sched_desc_valid,
  output logic  sched_desc_ready,
  input  desc_t core_data_desc,
  input  logic  core_data_desc_valid,
  output logic  core_data_desc_ready,
  output desc_t send_desc,
  output logic  send_desc_valid,
  input  logic  send_desc_ready,
  output desc_t sent_desc_latched
);

  desc_t     data_head;
  logic      data_head_valid;
  logic      data_head_ready;
  send_src_t grant;
  send_src_t held_grant;
  logic      locked;

  // Core data descriptor queue
  desc_fifo #(
    .DEPTH(`DESC_FIFO_DEPTH),
    .WIDTH($bits(desc_t))
  ) data_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (core_data_desc_valid),
    .din       (core_data_desc),
    .din_ready (core_data_desc_ready),
    .dout_valid(data_head_valid),
    .dout      (data_head),
    .dout_ready(data_head_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Priority arbiter
  always_comb begin
    if (locked)
      grant = held_grant;
    else if (sched_desc_valid)
      grant = SRC_SCHED;
    else
      grant = SRC_CORE_DATA;
  end

  // Stalled offer keeps its source next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      locked     <= 1'b0;
      held_grant <= SRC_SCHED;
    end else begin
      locked     <= send_desc_valid && !send_desc_ready;
      held_grant <= grant;
    end
  end

  assign send_desc_valid  = sched_desc_valid || data_head_valid;
  assign send_desc        = (grant == SRC_SCHED) ? sched_desc : data_head;
  assign sched_desc_ready = send_desc_ready && (grant == SRC_SCHED);
  assign data_head_ready  = send_desc_ready && (grant == SRC_CORE_DATA);

  // Last descriptor handed to the DMA, released on pkt_sent
  always_ff @(posedge clk) begin
    if (send_desc_valid && send_desc_ready)
      sent_desc_latched <= send_desc;
  end

  a_send_stable: assert property (@(posedge clk) disable iff (rst)
    (send_desc_valid && !send_desc_ready) |=> (send_desc_valid && $stable(send_desc)));

endmodule

/* source/sched_ctrl_in.sv */
////////////////////////////////////////////////////////////////////////////
// Scheduler beat decode. Reset commands wait for queue space like any beat
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_ctrl_defs.svh"

module sched_ctrl_in import desc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  desc_t ctrl_s_tdata,
  input  logic  ctrl_s_tvalid,
  output logic  ctrl_s_tready,
  output logic  core_reset,
  output desc_t sched_desc,
  output logic  sched_desc_valid,
  input  logic  sched_desc_ready
);

  desc_cmd_t cmd_byte;
  logic      reset_cmd;
  logic      beat_xfer;

  assign cmd_byte  = ctrl_s_tdata[DESC_CMD_LSB +: 8];
  assign reset_cmd = (cmd_byte == `RESET_CMD_BYTE);
  assign beat_xfer = ctrl_s_tvalid && ctrl_s_tready;

  // Core held in reset until the scheduler releases it
  always_ff @(posedge clk) begin
    if (rst)
      core_reset <= 1'b1;
    else if (beat_xfer && reset_cmd)
      core_reset <= ctrl_s_tdata[0];
  end

  // Send descriptors only, commands are dropped here
  desc_fifo #(
    .DEPTH(`DESC_FIFO_DEPTH),
    .WIDTH($bits(desc_t))
  ) sched_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (ctrl_s_tvalid && !reset_cmd),
    .din       (ctrl_s_tdata),
    .din_ready (ctrl_s_tready),
    .dout_valid(sched_desc_valid),
    .dout      (sched_desc),
    .dout_ready(sched_desc_ready)
  );

endmodule

/* source/desc_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Synchronous FIFO with a registered head, one cycle from push to dout.
// DEPTH must be a power of two, pointers wrap naturally
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module desc_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             din_valid,
  input  logic [WIDTH-1:0] din,
  output logic             din_ready,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  logic             dout_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int LVL_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Words held, array plus head register
  logic [LVL_W-1:0] level;
  logic             push;
  logic             pop;
  logic             load_out;
  logic             mem_empty;
  logic             mem_wr;
  logic             mem_rd;

  assign push      = din_valid && din_ready;
  assign pop       = dout_valid && dout_ready;
  assign din_ready = (level != LVL_W'(DEPTH));

  // Head register can take a new word
  assign load_out  = !dout_valid || pop;
  assign mem_empty = (level == LVL_W'(dout_valid));
  assign mem_rd    = load_out && !mem_empty;
  // Empty array with a free head, push goes straight to the head
  assign mem_wr    = push && !(load_out && mem_empty);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      level      <= '0;
      dout_valid <= 1'b0;
    end else begin
      if (mem_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (mem_rd)
        rd_ptr <= rd_ptr + 1'b1;
      level <= level + LVL_W'(push) - LVL_W'(pop);
      if (load_out)
        dout_valid <= mem_rd || push;
    end
  end

  // Storage and head data
  always_ff @(posedge clk) begin
    if (mem_wr)
      mem[wr_ptr] <= din;
    if (mem_rd)
      dout <= mem[rd_ptr];
    else if (load_out && push)
      dout <= din;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  // Array holds at most DEPTH-1 words, the head register holds the last
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    mem_wr |-> (level - LVL_W'(dout_valid)) < LVL_W'(DEPTH - 1));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> level != '0);

endmodule

/* source/msg_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Broadcast message fields. Strobe on top, then address, data at bit 0
////////////////////////////////////////////////////////////////////////////
`include "core_ctrl_defs.svh"

package msg_pkg;

  typedef logic [`MSG_WIDTH-1:0]       msg_t;
  typedef logic [3:0]                  msg_strb_t;
  typedef logic [`DMEM_ADDR_WIDTH-1:0] msg_addr_t;
  typedef logic [31:0]                 msg_data_t;

  localparam int MSG_DATA_LSB = 0;
  localparam int MSG_ADDR_LSB = 32;
  localparam int MSG_STRB_LSB = `MSG_WIDTH - 4;

  // 32-bit half of the 64-bit DMEM word, picked by address bit 2
  typedef enum logic {HALF_LOW = 1'b0, HALF_HIGH = 1'b1} word_half_t;

endpackage

/* source/desc_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Descriptor word and arbiter grant types
////////////////////////////////////////////////////////////////////////////
`include "core_ctrl_defs.svh"

package desc_pkg;

  // Descriptor layout, low to high
  //   [15:0]  length
  //   [23:16] slot
  //   [31:24] port
  //   [63:32] address
  typedef logic [`CTRL_DATA_WIDTH-1:0] desc_t;

  // Top byte, carries the reset command marker
  typedef logic [7:0] desc_cmd_t;
  localparam int DESC_CMD_LSB = `CTRL_DATA_WIDTH - 8;

  // Send arbiter grant, scheduler wins ties
  typedef enum logic {SRC_SCHED, SRC_CORE_DATA} send_src_t;

  // Control output arbiter grant, release wins ties
  typedef enum logic {SRC_RELEASE, SRC_CORE_CTRL} ctrl_src_t;

endpackage

/* source/core_ctrl_defs.svh */
////////////////////////////////////////////////////////////////////////////
// Global widths and depths of the control plane. FIFO depths must be
// powers of two. MSG_WIDTH has to track DMEM_ADDR_WIDTH by hand
////////////////////////////////////////////////////////////////////////////
`ifndef CORE_CTRL_DEFS_SVH
`define CORE_CTRL_DEFS_SVH

// Control beat and descriptor width
`define CTRL_DATA_WIDTH 64

// Queue depths
`define DESC_FIFO_DEPTH 8
`define MSG_FIFO_DEPTH  16

// 32 KB data memory, byte addressed
`define DMEM_ADDR_WIDTH 15

// Strobe(4) + address(15) + data(32)
`define MSG_WIDTH 51

// Core identity on the outgoing control channel
`define CORE_ID_WIDTH 4
`define CORE_ID       4'd3

// Top byte marking a core reset command
`define RESET_CMD_BYTE 8'hFF

`endif
